//--- include/id_consts.svh
`ifndef ID_CONSTS_SVH
`define ID_CONSTS_SVH

`define ID_XLEN      32
`define ID_NREG      32
`define ID_REG_W     5
`define ID_LINK_REG  5'd1     // bl writes the return address here
`define ID_ALU_W     12
`define ID_BR_W      9

// major opcode, inst[31:26]
`define OP6_SPECIAL    6'h00
`define OP6_LU12I      6'h05  // with inst[25] clear
`define OP6_PCADDU12I  6'h07  // with inst[25] clear
`define OP6_JIRL       6'h13
`define OP6_B          6'h14
`define OP6_BL         6'h15
`define OP6_BEQ        6'h16
`define OP6_BNE        6'h17
`define OP6_BLT        6'h18
`define OP6_BGE        6'h19
`define OP6_BLTU       6'h1a
`define OP6_BGEU       6'h1b

// inst[25:22] under the special opcode
`define OP4_3R      4'h0
`define OP4_SHIFTI  4'h1
`define OP4_SLTI    4'h8
`define OP4_SLTUI   4'h9
`define OP4_ADDI    4'ha
`define OP4_ANDI    4'hd
`define OP4_ORI     4'he
`define OP4_XORI    4'hf

// inst[21:20]
`define OP2_3R      2'h1
`define OP2_SHIFTI  2'h0

// inst[19:15], register-register group
`define OP5_ADD   5'h00
`define OP5_SUB   5'h02
`define OP5_SLT   5'h04
`define OP5_SLTU  5'h05
`define OP5_NOR   5'h08
`define OP5_AND   5'h09
`define OP5_OR    5'h0a
`define OP5_XOR   5'h0b
`define OP5_SLL   5'h0e
`define OP5_SRL   5'h0f
`define OP5_SRA   5'h10

// inst[19:15], shift-immediate group
`define OP5_SLLI  5'h01
`define OP5_SRLI  5'h09
`define OP5_SRAI  5'h11

// alu_op one-hot bit positions
`define ALU_ADD   0
`define ALU_SUB   1
`define ALU_SLT   2
`define ALU_SLTU  3
`define ALU_AND   4
`define ALU_NOR   5
`define ALU_OR    6
`define ALU_XOR   7
`define ALU_SLL   8
`define ALU_SRL   9
`define ALU_SRA   10
`define ALU_LUI   11

// br_kind one-hot bit positions
`define BR_BEQ    0
`define BR_BNE    1
`define BR_BLT    2
`define BR_BGE    3
`define BR_BLTU   4
`define BR_BGEU   5
`define BR_JIRL   6
`define BR_B      7
`define BR_BL     8

`endif

//--- verilog/id_pkg.sv
`include "id_consts.svh"

package id_pkg;

    // data or address word
    typedef logic [`ID_XLEN-1:0] word_t;

    // register file index
    typedef logic [`ID_REG_W-1:0] reg_addr_t;

    // one-hot alu operation, bits named by the ALU_ macros
    typedef logic [`ID_ALU_W-1:0] alu_op_t;

    // one-hot branch kind, all zero when not a branch
    typedef logic [`ID_BR_W-1:0] br_kind_t;

endpackage

//--- verilog/inst_decoder.sv
`timescale 1ns/1ps
`include "id_consts.svh"

module inst_decoder
    import id_pkg::*;
(
    input  word_t     inst,
    output alu_op_t   alu_op,
    output br_kind_t  br_kind,
    output reg_addr_t rj,
    output reg_addr_t rkd,
    output logic      use_rj,
    output logic      use_rkd,
    output word_t     imm,
    output logic      src1_is_pc,
    output logic      src2_is_imm,
    output reg_addr_t dest,
    output logic      gr_we,
    output logic      ine
);

    logic [5:0]  op6;
    logic [3:0]  op4;
    logic [1:0]  op2;
    logic [4:0]  op5;
    logic [11:0] i12;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [25:0] i26;
    logic        grp_3r, grp_shi, grp_imm;
    logic        add_w, sub_w, slt, sltu, nor_i, and_i, or_i, xor_i, sll_w, srl_w, sra_w;
    logic        slli_w, srli_w, srai_w;
    logic        addi_w, slti, sltui, andi, ori, xori;
    logic        lu12i_w, pcaddu12i;
    logic        jirl, b, bl, beq, bne, blt, bge, bltu, bgeu;
    logic        cond_br;
    logic        known;

    assign op6 = inst[31:26];
    assign op4 = inst[25:22];
    assign op2 = inst[21:20];
    assign op5 = inst[19:15];
    assign i12 = inst[21:10];
    assign i16 = inst[25:10];
    assign i20 = inst[24:5];
    assign i26 = {inst[9:0], inst[25:10]};   // offs[25:16] sits in the low bits

    assign grp_imm = (op6 == `OP6_SPECIAL);
    assign grp_3r  = grp_imm && (op4 == `OP4_3R) && (op2 == `OP2_3R);
    assign grp_shi = grp_imm && (op4 == `OP4_SHIFTI) && (op2 == `OP2_SHIFTI);

    assign add_w  = grp_3r && (op5 == `OP5_ADD);
    assign sub_w  = grp_3r && (op5 == `OP5_SUB);
    assign slt    = grp_3r && (op5 == `OP5_SLT);
    assign sltu   = grp_3r && (op5 == `OP5_SLTU);
    assign nor_i  = grp_3r && (op5 == `OP5_NOR);
    assign and_i  = grp_3r && (op5 == `OP5_AND);
    assign or_i   = grp_3r && (op5 == `OP5_OR);
    assign xor_i  = grp_3r && (op5 == `OP5_XOR);
    assign sll_w  = grp_3r && (op5 == `OP5_SLL);
    assign srl_w  = grp_3r && (op5 == `OP5_SRL);
    assign sra_w  = grp_3r && (op5 == `OP5_SRA);
    assign slli_w = grp_shi && (op5 == `OP5_SLLI);
    assign srli_w = grp_shi && (op5 == `OP5_SRLI);
    assign srai_w = grp_shi && (op5 == `OP5_SRAI);

    assign addi_w = grp_imm && (op4 == `OP4_ADDI);
    assign slti   = grp_imm && (op4 == `OP4_SLTI);
    assign sltui  = grp_imm && (op4 == `OP4_SLTUI);
    assign andi   = grp_imm && (op4 == `OP4_ANDI);
    assign ori    = grp_imm && (op4 == `OP4_ORI);
    assign xori   = grp_imm && (op4 == `OP4_XORI);

    assign lu12i_w   = (op6 == `OP6_LU12I) && !inst[25];
    assign pcaddu12i = (op6 == `OP6_PCADDU12I) && !inst[25];

    assign jirl = (op6 == `OP6_JIRL);
    assign b    = (op6 == `OP6_B);
    assign bl   = (op6 == `OP6_BL);
    assign beq  = (op6 == `OP6_BEQ);
    assign bne  = (op6 == `OP6_BNE);
    assign blt  = (op6 == `OP6_BLT);
    assign bge  = (op6 == `OP6_BGE);
    assign bltu = (op6 == `OP6_BLTU);
    assign bgeu = (op6 == `OP6_BGEU);

    assign cond_br = beq | bne | blt | bge | bltu | bgeu;

    assign known = add_w | sub_w | slt | sltu | nor_i | and_i | or_i | xor_i
                 | sll_w | srl_w | sra_w | slli_w | srli_w | srai_w
                 | addi_w | slti | sltui | andi | ori | xori
                 | lu12i_w | pcaddu12i | jirl | b | bl | cond_br;

    assign ine = !known;

    assign alu_op[`ALU_ADD]  = add_w | addi_w | jirl | bl | pcaddu12i;  // link adds pc + 4
    assign alu_op[`ALU_SUB]  = sub_w;
    assign alu_op[`ALU_SLT]  = slt | slti;
    assign alu_op[`ALU_SLTU] = sltu | sltui;
    assign alu_op[`ALU_AND]  = and_i | andi;
    assign alu_op[`ALU_NOR]  = nor_i;
    assign alu_op[`ALU_OR]   = or_i | ori;
    assign alu_op[`ALU_XOR]  = xor_i | xori;
    assign alu_op[`ALU_SLL]  = sll_w | slli_w;
    assign alu_op[`ALU_SRL]  = srl_w | srli_w;
    assign alu_op[`ALU_SRA]  = sra_w | srai_w;
    assign alu_op[`ALU_LUI]  = lu12i_w;

    assign br_kind = {bl, b, jirl, bgeu, bltu, bge, blt, bne, beq};

    assign use_rj  = known && !(lu12i_w | pcaddu12i | b | bl);
    assign use_rkd = grp_3r && known || cond_br;

    assign rj   = known ? inst[9:5] : '0;
    assign rkd  = !known ? '0 : cond_br ? inst[4:0] : inst[14:10];  // branches compare rd
    assign dest = !known ? '0 : bl ? `ID_LINK_REG : inst[4:0];

    assign gr_we       = known && !(b | cond_br);
    assign src1_is_pc  = jirl | bl | pcaddu12i;
    assign src2_is_imm = slli_w | srli_w | srai_w | addi_w | slti | sltui | andi | ori | xori
                       | lu12i_w | pcaddu12i | jirl | bl;

    // for control flow imm is the branch offset; link value 4 is set downstream
    always_comb begin
        if (slli_w | srli_w | srai_w)
            imm = {27'b0, inst[14:10]};                 // ui5
        else if (andi | ori | xori)
            imm = {20'b0, i12};
        else if (addi_w | slti | sltui)
            imm = {{20{i12[11]}}, i12};
        else if (lu12i_w | pcaddu12i)
            imm = {i20, 12'b0};
        else if (b | bl)
            imm = {{4{i26[25]}}, i26, 2'b0};
        else if (jirl | cond_br)
            imm = {{14{i16[15]}}, i16, 2'b0};
        else
            imm = '0;
    end

endmodule

//--- verilog/id_decode.sv
`timescale 1ns/1ps

module id_decode
    import id_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  logic      in_valid,
    output logic      in_ready,
    input  word_t     in_pc,
    input  word_t     in_inst,
    input  logic      squash,
    output logic      dec_valid,
    input  logic      dec_ready,
    output word_t     dec_pc,
    output alu_op_t   dec_alu_op,
    output br_kind_t  dec_br_kind,
    output reg_addr_t dec_rj,
    output reg_addr_t dec_rkd,
    output logic      dec_use_rj,
    output logic      dec_use_rkd,
    output word_t     dec_imm,
    output logic      dec_src1_is_pc,
    output logic      dec_src2_is_imm,
    output reg_addr_t dec_dest,
    output logic      dec_gr_we,
    output logic      dec_ine
);

    logic      running;     // low through reset, keeps in_ready off
    logic      drop_next;   // squash arrived with no younger item to kill
    logic      in_fire;
    logic      dec_fire;
    alu_op_t   d_alu_op;
    br_kind_t  d_br_kind;
    reg_addr_t d_rj, d_rkd, d_dest;
    logic      d_use_rj, d_use_rkd, d_src1_is_pc, d_src2_is_imm, d_gr_we, d_ine;
    word_t     d_imm;

    inst_decoder u_inst_decoder (
        .inst        (in_inst),
        .alu_op      (d_alu_op),
        .br_kind     (d_br_kind),
        .rj          (d_rj),
        .rkd         (d_rkd),
        .use_rj      (d_use_rj),
        .use_rkd     (d_use_rkd),
        .imm         (d_imm),
        .src1_is_pc  (d_src1_is_pc),
        .src2_is_imm (d_src2_is_imm),
        .dest        (d_dest),
        .gr_we       (d_gr_we),
        .ine         (d_ine)
    );

    assign in_ready = running && (!dec_valid || dec_ready);
    assign in_fire  = in_valid && in_ready;
    assign dec_fire = dec_valid && dec_ready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            running   <= 1'b0;
            dec_valid <= 1'b0;
            drop_next <= 1'b0;
        end else begin
            running <= 1'b1;
            if (in_fire) begin
                dec_valid <= !(squash || drop_next);  // wrong-path slot is discarded
                drop_next <= 1'b0;
            end else begin
                if (dec_fire)
                    dec_valid <= 1'b0;
                if (squash)
                    drop_next <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            dec_pc          <= in_pc;
            dec_alu_op      <= d_alu_op;
            dec_br_kind     <= d_br_kind;
            dec_rj          <= d_rj;
            dec_rkd         <= d_rkd;
            dec_use_rj      <= d_use_rj;
            dec_use_rkd     <= d_use_rkd;
            dec_imm         <= d_imm;
            dec_src1_is_pc  <= d_src1_is_pc;
            dec_src2_is_imm <= d_src2_is_imm;
            dec_dest        <= d_dest;
            dec_gr_we       <= d_gr_we;
            dec_ine         <= d_ine;
        end
    end

endmodule

//--- verilog/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic              clk,
    input  id_pkg::reg_addr_t raddr1,
    output id_pkg::word_t     rdata1,
    input  id_pkg::reg_addr_t raddr2,
    output id_pkg::word_t     rdata2,
    input  logic              we,
    input  id_pkg::reg_addr_t waddr,
    input  id_pkg::word_t     wdata
);

    localparam int NREG = 2 ** $bits(id_pkg::reg_addr_t);

    id_pkg::word_t regs [NREG];

    always_ff @(posedge clk) begin
        if (we)
            regs[waddr] <= wdata;   // r0 storage is never read
    end

    // same-cycle write is forwarded to the read ports
    always_comb begin
        if (raddr1 == '0)
            rdata1 = '0;
        else if (we && waddr == raddr1)
            rdata1 = wdata;
        else
            rdata1 = regs[raddr1];
    end

    always_comb begin
        if (raddr2 == '0)
            rdata2 = '0;
        else if (we && waddr == raddr2)
            rdata2 = wdata;
        else
            rdata2 = regs[raddr2];
    end

endmodule

//--- verilog/id_operand.sv
`timescale 1ns/1ps
`include "id_consts.svh"

module id_operand
    import id_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    output logic      squash,
    input  logic      dec_valid,
    output logic      dec_ready,
    input  word_t     dec_pc,
    input  alu_op_t   dec_alu_op,
    input  br_kind_t  dec_br_kind,
    input  reg_addr_t dec_rj,
    input  reg_addr_t dec_rkd,
    input  logic      dec_use_rj,
    input  logic      dec_use_rkd,
    input  word_t     dec_imm,
    input  logic      dec_src1_is_pc,
    input  logic      dec_src2_is_imm,
    input  reg_addr_t dec_dest,
    input  logic      dec_gr_we,
    input  logic      dec_ine,
    input  logic      wb_we,
    input  reg_addr_t wb_addr,
    input  word_t     wb_data,
    output logic      out_valid,
    input  logic      out_ready,
    output word_t     out_pc,
    output alu_op_t   out_alu_op,
    output word_t     out_src1,
    output word_t     out_src2,
    output reg_addr_t out_dest,
    output logic      out_gr_we,
    output logic      out_ine,
    output logic      out_br_taken,
    output word_t     out_br_target
);

    word_t rf_rdata1, rf_rdata2;
    word_t rj_value, rkd_value;
    word_t src1, src2;
    word_t br_target;
    logic  dec_fire;
    logic  rj_eq, rj_lt, rj_ltu;
    logic  is_link;
    logic  br_taken;

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (dec_rj),
        .rdata1 (rf_rdata1),
        .raddr2 (dec_rkd),
        .rdata2 (rf_rdata2),
        .we     (wb_we),
        .waddr  (wb_addr),
        .wdata  (wb_data)
    );

    assign rj_value  = dec_use_rj ? rf_rdata1 : '0;   // unused fields read as zero
    assign rkd_value = dec_use_rkd ? rf_rdata2 : '0;

    assign rj_eq  = (rj_value == rkd_value);
    assign rj_lt  = ($signed(rj_value) < $signed(rkd_value));
    assign rj_ltu = (rj_value < rkd_value);

    assign br_taken = dec_br_kind[`BR_BEQ]  &&  rj_eq
                   || dec_br_kind[`BR_BNE]  && !rj_eq
                   || dec_br_kind[`BR_BLT]  &&  rj_lt
                   || dec_br_kind[`BR_BGE]  && !rj_lt
                   || dec_br_kind[`BR_BLTU] &&  rj_ltu
                   || dec_br_kind[`BR_BGEU] && !rj_ltu
                   || dec_br_kind[`BR_JIRL]
                   || dec_br_kind[`BR_B]
                   || dec_br_kind[`BR_BL];

    // jirl is register-relative, every other branch is pc-relative
    assign br_target = dec_br_kind[`BR_JIRL] ? rj_value + dec_imm : dec_pc + dec_imm;

    assign is_link = dec_br_kind[`BR_JIRL] || dec_br_kind[`BR_BL];
    assign src1    = dec_src1_is_pc ? dec_pc : rj_value;
    assign src2    = !dec_src2_is_imm ? rkd_value :
                     is_link          ? word_t'(4) : dec_imm;   // return address pc + 4

    assign dec_ready = !out_valid || out_ready;
    assign dec_fire  = dec_valid && dec_ready;
    assign squash    = dec_fire && br_taken;

    always_ff @(posedge clk) begin
        if (!resetn)
            out_valid <= 1'b0;
        else if (dec_ready)
            out_valid <= dec_valid;
    end

    always_ff @(posedge clk) begin
        if (dec_fire) begin
            out_pc        <= dec_pc;
            out_alu_op    <= dec_alu_op;
            out_src1      <= src1;
            out_src2      <= src2;
            out_dest      <= dec_dest;
            out_gr_we     <= dec_gr_we;
            out_ine       <= dec_ine;
            out_br_taken  <= br_taken;
            out_br_target <= br_target;
        end
    end

endmodule

//--- verilog/id_top.sv
`timescale 1ns/1ps

module id_top
    import id_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  logic      in_valid,
    output logic      in_ready,
    input  word_t     in_pc,
    input  word_t     in_inst,
    input  logic      wb_we,
    input  reg_addr_t wb_addr,
    input  word_t     wb_data,
    output logic      out_valid,
    input  logic      out_ready,
    output word_t     out_pc,
    output alu_op_t   out_alu_op,
    output word_t     out_src1,
    output word_t     out_src2,
    output reg_addr_t out_dest,
    output logic      out_gr_we,
    output logic      out_ine,
    output logic      out_br_taken,
    output word_t     out_br_target
);

    logic      squash;
    logic      dec_valid, dec_ready;
    word_t     dec_pc, dec_imm;
    alu_op_t   dec_alu_op;
    br_kind_t  dec_br_kind;
    reg_addr_t dec_rj, dec_rkd, dec_dest;
    logic      dec_use_rj, dec_use_rkd, dec_src1_is_pc, dec_src2_is_imm;
    logic      dec_gr_we, dec_ine;

    // stage 1, decode and register controls
    id_decode u_decode (
        .clk             (clk),
        .resetn          (resetn),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .in_pc           (in_pc),
        .in_inst         (in_inst),
        .squash          (squash),
        .dec_valid       (dec_valid),
        .dec_ready       (dec_ready),
        .dec_pc          (dec_pc),
        .dec_alu_op      (dec_alu_op),
        .dec_br_kind     (dec_br_kind),
        .dec_rj          (dec_rj),
        .dec_rkd         (dec_rkd),
        .dec_use_rj      (dec_use_rj),
        .dec_use_rkd     (dec_use_rkd),
        .dec_imm         (dec_imm),
        .dec_src1_is_pc  (dec_src1_is_pc),
        .dec_src2_is_imm (dec_src2_is_imm),
        .dec_dest        (dec_dest),
        .dec_gr_we       (dec_gr_we),
        .dec_ine         (dec_ine)
    );

    // stage 2, operands and branch resolve
    id_operand u_operand (
        .clk             (clk),
        .resetn          (resetn),
        .squash          (squash),
        .dec_valid       (dec_valid),
        .dec_ready       (dec_ready),
        .dec_pc          (dec_pc),
        .dec_alu_op      (dec_alu_op),
        .dec_br_kind     (dec_br_kind),
        .dec_rj          (dec_rj),
        .dec_rkd         (dec_rkd),
        .dec_use_rj      (dec_use_rj),
        .dec_use_rkd     (dec_use_rkd),
        .dec_imm         (dec_imm),
        .dec_src1_is_pc  (dec_src1_is_pc),
        .dec_src2_is_imm (dec_src2_is_imm),
        .dec_dest        (dec_dest),
        .dec_gr_we       (dec_gr_we),
        .dec_ine         (dec_ine),
        .wb_we           (wb_we),
        .wb_addr         (wb_addr),
        .wb_data         (wb_data),
        .out_valid       (out_valid),
        .out_ready       (out_ready),
        .out_pc          (out_pc),
        .out_alu_op      (out_alu_op),
        .out_src1        (out_src1),
        .out_src2        (out_src2),
        .out_dest        (out_dest),
        .out_gr_we       (out_gr_we),
        .out_ine         (out_ine),
        .out_br_taken    (out_br_taken),
        .out_br_target   (out_br_target)
    );

endmodule

//--- bench/tb_id_top.sv
`timescale 1ns/1ps
`include "id_consts.svh"

module tb_id_top
    import id_pkg::*;
();

    typedef struct packed {
        word_t     pc;
        alu_op_t   alu_op;
        word_t     src1;
        word_t     src2;
        reg_addr_t dest;
        logic      gr_we;
        logic      ine;
        logic      br_taken;
        logic      is_br;       // target compared only for control flow
        word_t     br_target;
    } exp_t;

    // encoding tables, index picked at random
    localparam logic [4:0] rr_op5 [11] = '{`OP5_ADD, `OP5_SUB, `OP5_SLT, `OP5_SLTU, `OP5_NOR,
        `OP5_AND, `OP5_OR, `OP5_XOR, `OP5_SLL, `OP5_SRL, `OP5_SRA};
    localparam int rr_alu [11] = '{`ALU_ADD, `ALU_SUB, `ALU_SLT, `ALU_SLTU, `ALU_NOR,
        `ALU_AND, `ALU_OR, `ALU_XOR, `ALU_SLL, `ALU_SRL, `ALU_SRA};
    localparam logic [4:0] sh_op5 [3] = '{`OP5_SLLI, `OP5_SRLI, `OP5_SRAI};
    localparam int sh_alu [3] = '{`ALU_SLL, `ALU_SRL, `ALU_SRA};
    localparam logic [3:0] im_op4 [6] = '{`OP4_SLTI, `OP4_SLTUI, `OP4_ADDI,
        `OP4_ANDI, `OP4_ORI, `OP4_XORI};
    localparam int im_alu [6] = '{`ALU_SLT, `ALU_SLTU, `ALU_ADD, `ALU_AND, `ALU_OR, `ALU_XOR};
    localparam logic [5:0] br_op6 [6] = '{`OP6_BEQ, `OP6_BNE, `OP6_BLT, `OP6_BGE,
        `OP6_BLTU, `OP6_BGEU};

    logic        clk = 1'b0;
    logic        resetn;
    logic        in_valid, in_ready;
    word_t       in_pc, in_inst;
    logic        wb_we;
    reg_addr_t   wb_addr;
    word_t       wb_data;
    logic        out_valid;
    logic        out_ready = 1'b1;
    word_t       out_pc, out_src1, out_src2, out_br_target;
    alu_op_t     out_alu_op;
    reg_addr_t   out_dest;
    logic        out_gr_we, out_ine, out_br_taken;

    integer      seed;
    word_t       model_regs [`ID_NREG];
    exp_t        exp_q [$];     // expected outputs in order
    exp_t        cur_exp;       // travels with in_inst
    exp_t        held_out, exp_item;
    logic        held_valid, skip_next, bp_on;
    logic [1023:0] ready_pattern;
    logic [9:0]  cyc = '0;
    word_t       next_pc;
    int          n_out;

    id_top dut (
        .clk           (clk),
        .resetn        (resetn),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_pc         (in_pc),
        .in_inst       (in_inst),
        .wb_we         (wb_we),
        .wb_addr       (wb_addr),
        .wb_data       (wb_data),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_pc        (out_pc),
        .out_alu_op    (out_alu_op),
        .out_src1      (out_src1),
        .out_src2      (out_src2),
        .out_dest      (out_dest),
        .out_gr_we     (out_gr_we),
        .out_ine       (out_ine),
        .out_br_taken  (out_br_taken),
        .out_br_target (out_br_target)
    );

    always #4 clk = ~clk;

    function automatic word_t rf_read(input reg_addr_t a);
        return (a == '0) ? '0 : model_regs[a];    // r0 is hardwired
    endfunction

    function automatic word_t branch_offset16(input logic [15:0] v);
        return {{14{v[15]}}, v, 2'b00};
    endfunction

    function automatic exp_t capture_outputs();
        exp_t c;
        c = '{out_pc, out_alu_op, out_src1, out_src2, out_dest, out_gr_we, out_ine,
              out_br_taken, 1'b1, out_br_target};
        return c;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
            stop_on_error($sformatf("CHECK FAILED at %0t ns: %s, got %08h expected %08h",
                                    $time, what, actual, expected));
    endtask

    task automatic compare_outputs(input string tag, input exp_t e);
        check_value({tag, " pc"}, out_pc, e.pc);
        check_value({tag, " alu_op"}, 32'(out_alu_op), 32'(e.alu_op));
        check_value({tag, " src1"}, out_src1, e.src1);
        check_value({tag, " src2"}, out_src2, e.src2);
        check_value({tag, " dest"}, 32'(out_dest), 32'(e.dest));
        check_value({tag, " gr_we"}, 32'(out_gr_we), 32'(e.gr_we));
        check_value({tag, " ine"}, 32'(out_ine), 32'(e.ine));
        check_value({tag, " br_taken"}, 32'(out_br_taken), 32'(e.br_taken));
        if (e.is_br)
            check_value({tag, " br_target"}, out_br_target, e.br_target);
    endtask

    task automatic apply_reset();
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_value("in_ready during reset", 32'(in_ready), 32'd0);
        check_value("out_valid during reset", 32'(out_valid), 32'd0);
        @(posedge clk);
        resetn <= 1'b1;
    endtask

    // only called with the pipeline empty and in_valid low
    task automatic write_regs(input int count, input bit in_order);
        logic [31:0] r;
        reg_addr_t   a;
        word_t       d;
        for (int i = 0; i < count; i++) begin
            r = $random(seed);
            d = $random(seed);
            a = in_order ? reg_addr_t'(i) : r[4:0];
            wb_we   <= 1'b1;
            wb_addr <= a;
            wb_data <= d;
            @(posedge clk);
            model_regs[a] = d;
        end
        wb_we <= 1'b0;
    endtask

    task automatic make_inst(input int kind, input word_t pc, output word_t inst,
                             output exp_t e);
        logic [31:0] r;
        logic [31:0] f;
        reg_addr_t   rd, rj, rk;
        int          sel;
        word_t       a, d;
        r  = $random(seed);
        f  = $random(seed);
        rd = r[4:0];
        rj = r[9:5];
        rk = r[14:10];
        if (r[17:15] == 3'd0) begin   // equal sources now and then
            rk = rj;
            rd = rj;
        end
        sel     = int'(r[27:20]);
        inst    = '0;
        e       = '0;
        e.pc    = pc;
        e.dest  = rd;
        e.gr_we = 1'b1;
        case (kind)
            0: begin
                sel = sel % 11;
                inst = {`OP6_SPECIAL, `OP4_3R, `OP2_3R, rr_op5[sel], rk, rj, rd};
                e.alu_op[rr_alu[sel]] = 1'b1;
                e.src1 = rf_read(rj);
                e.src2 = rf_read(rk);
            end
            1: begin
                sel = sel % 3;
                inst = {`OP6_SPECIAL, `OP4_SHIFTI, `OP2_SHIFTI, sh_op5[sel], f[4:0], rj, rd};
                e.alu_op[sh_alu[sel]] = 1'b1;
                e.src1 = rf_read(rj);
                e.src2 = {27'b0, f[4:0]};
            end
            2: begin
                sel = sel % 6;
                inst = {`OP6_SPECIAL, im_op4[sel], f[11:0], rj, rd};
                e.alu_op[im_alu[sel]] = 1'b1;
                e.src1 = rf_read(rj);
                e.src2 = (sel < 3) ? {{20{f[11]}}, f[11:0]} : {20'b0, f[11:0]};  // logic ops
            end
            3, 4: begin
                inst = {(kind == 3) ? `OP6_LU12I : `OP6_PCADDU12I, 1'b0, f[19:0], rd};
                e.alu_op[(kind == 3) ? `ALU_LUI : `ALU_ADD] = 1'b1;
                e.src1 = (kind == 3) ? '0 : pc;
                e.src2 = {f[19:0], 12'b0};
            end
            5: begin
                inst = {`OP6_JIRL, f[15:0], rj, rd};
                e.alu_op[`ALU_ADD] = 1'b1;
                e.src1 = pc;
                e.src2 = 32'd4;
                e.br_taken = 1'b1;
                e.is_br = 1'b1;
                e.br_target = rf_read(rj) + branch_offset16(f[15:0]);
            end
            6, 7: begin
                // offs[25:16] sits in the low ten bits
                inst = {(kind == 6) ? `OP6_B : `OP6_BL, f[15:0], f[25:16]};
                e.br_taken = 1'b1;
                e.is_br = 1'b1;
                e.br_target = pc + {{4{f[25]}}, f[25:0], 2'b00};
                if (kind == 6) begin
                    e.dest = f[20:16];    // rd field holds offset bits
                    e.gr_we = 1'b0;
                end else begin
                    e.alu_op[`ALU_ADD] = 1'b1;
                    e.src1 = pc;
                    e.src2 = 32'd4;
                    e.dest = `ID_LINK_REG;
                end
            end
            8: begin
                sel = sel % 6;
                inst = {br_op6[sel], f[15:0], rj, rd};
                a = rf_read(rj);
                d = rf_read(rd);          // conditional branches compare rd
                e.src1 = a;
                e.src2 = d;
                e.gr_we = 1'b0;
                e.is_br = 1'b1;
                e.br_target = pc + branch_offset16(f[15:0]);
                case (sel)
                    0: e.br_taken = (a == d);
                    1: e.br_taken = (a != d);
                    2: e.br_taken = ($signed(a) < $signed(d));
                    3: e.br_taken = ($signed(a) >= $signed(d));
                    4: e.br_taken = (a < d);
                    default: e.br_taken = (a >= d);
                endcase
            end
            default: begin
                case (f[9:8])
                    2'd0: inst = {6'(28 + int'(f[7:0]) % 36), r[25:0]};   // opcodes 0x1c..0x3f
                    2'd1: inst = {`OP6_SPECIAL, 4'(2 + int'(f[7:0]) % 6), r[21:0]};
                    2'd2: inst = {f[10] ? `OP6_LU12I : `OP6_PCADDU12I, 1'b1, r[24:0]};
                    default:    // unused register-register slots
                        inst = {`OP6_SPECIAL, `OP4_3R, `OP2_3R, 5'(17 + int'(f[7:0]) % 15),
                                r[14:0]};
                endcase
                e.dest = '0;
                e.gr_we = 1'b0;
                e.ine = 1'b1;
            end
        endcase
    endtask

    task automatic send_inst(input word_t inst, input exp_t e);
        logic [31:0] r;
        int          waited;
        r = $random(seed);
        if (bp_on && r[1:0] == 2'd0) begin
            in_valid <= 1'b0;
            repeat (int'(r[3:2]) + 1) @(posedge clk);
        end
        in_valid <= 1'b1;
        in_pc    <= e.pc;
        in_inst  <= inst;
        cur_exp  <= e;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > 100)
                stop_on_error("timeout waiting for in_ready");
        end while (!in_ready);
    endtask

    task automatic drain();
        int waited;
        in_valid <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > 500)
                stop_on_error("timeout waiting for the pipeline to drain");
        end while (exp_q.size() != 0 || out_valid);
        @(posedge clk);
    endtask

    task automatic run_batch(input int count, input int lo, input int hi);
        logic [31:0] r;
        int          kind;
        word_t       inst;
        exp_t        e;
        for (int i = 0; i < count; i++) begin
            r = $random(seed);
            kind = lo + int'(r[7:0]) % (hi - lo + 1);
            make_inst(kind, next_pc, inst, e);
            send_inst(inst, e);
            next_pc = next_pc + 32'd4;
        end
        drain();
    endtask

    // random out_ready only while back-pressure is on
    always @(posedge clk) begin
        cyc <= cyc + 1'b1;
        out_ready <= bp_on ? ready_pattern[cyc] : 1'b1;
    end

    // reference model, tracks accepted instructions and checks every output
    always @(posedge clk) begin
        if (!resetn) begin
            skip_next  = 1'b0;
            held_valid = 1'b0;
        end else begin
            if (held_valid) begin
                check_value("out_valid while stalled", 32'(out_valid), 32'd1);
                compare_outputs("stalled", held_out);
            end
            held_valid = out_valid && !out_ready;
            held_out   = capture_outputs();
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    stop_on_error("output transfer with no instruction expected");
                end else begin
                    exp_item = exp_q.pop_front();
                    compare_outputs("output", exp_item);
                    n_out++;
                end
            end
            if (in_valid && in_ready) begin
                if (skip_next) begin
                    skip_next = 1'b0;         // wrong-path slot never comes out
                end else begin
                    exp_q.push_back(cur_exp);
                    if (cur_exp.br_taken)
                        skip_next = 1'b1;
                end
            end
        end
    end

    initial begin
        logic [31:0] r;
        seed     = 32'h695590ce;
        resetn   = 1'b0;
        in_valid = 1'b0;
        in_pc    = '0;
        in_inst  = '0;
        wb_we    = 1'b0;
        wb_addr  = '0;
        wb_data  = '0;
        bp_on    = 1'b0;
        cur_exp  = '0;
        n_out    = 0;
        next_pc  = 32'h1c00_0000;
        for (int i = 0; i < 32; i++) begin
            r = $random(seed) | $random(seed);    // ready high about 3 in 4
            ready_pattern[i*32 +: 32] = r;
        end
        apply_reset();
        write_regs(32, 1'b1);     // every register, r0 too
        write_regs(20, 1'b0);
        run_batch(80, 0, 0);      // register-register
        run_batch(100, 1, 4);     // immediate forms
        write_regs(24, 1'b0);
        run_batch(150, 5, 8);     // control flow
        run_batch(40, 9, 9);      // illegal words
        bp_on <= 1'b1;
        run_batch(300, 0, 9);
        $display("%0d instructions checked", n_out);
        $display("All tests passed!");
        $finish;
    end

endmodule

//--- tb.f
+incdir+include
verilog/id_pkg.sv
verilog/inst_decoder.sv
verilog/id_decode.sv
verilog/regfile.sv
verilog/id_operand.sv
verilog/id_top.sv
bench/tb_id_top.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --timing
TOP       = tb_id_top
FILELIST  = tb.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test failures found" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	elif ! grep -q "All tests passed!" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
